//--- vlog.f
source/sms_pkg.sv
source/cpu_bus_if.sv
source/sms_io_decode.sv
source/vdp_port.sv
source/vdp_status.sv
source/mem_mapper.sv
source/sms_read_mux.sv
source/sms_system.sv
test/tb_sms_system.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_sms_system -f vlog.f &&
./obj_dir/Vtb_sms_system | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- test/tb_sms_system.sv
module tb_sms_system;
  timeunit 1ns;
  timeprecision 100ps;
  import sms_pkg::*;

  localparam int CLK_DIV     = 7;
  localparam int NUM_OPS     = 400;
  localparam int RUN_CYC     = NUM_OPS * CLK_DIV + 6;   // Every op plus the first edge
  localparam int TIMEOUT_CYC = NUM_OPS * CLK_DIV + 1200;

  logic        cpuClock;
  logic        n_hard_reset;
  cpu_addr_t   i_addr;
  byte_t       i_wdata;
  logic        i_n_rd, i_n_wr, i_n_iorq, i_n_mreq;
  logic        i_frame_int, i_sprite_collision, i_too_many_sprites;
  sprite_idx_t i_overflow_sprite;
  byte_t       i_vram_data, i_v_counter, i_h_counter;
  logic [6:0]  i_btn;
  byte_t       i_ram_data, i_bios_data, i_rom_data;

  logic        o_cpu_clk_en, o_vdp_wr, o_vdp_rd, o_cram_selected;
  byte_t       o_cpu_data_in, o_x_scroll, o_y_scroll;
  vram_addr_t  o_vdp_addr, o_name_table_addr, o_color_table_addr, o_pattern_addr;
  vram_addr_t  o_sprite_attr_addr, o_sprite_pattern_addr;
  logic [2:0]  o_mode;
  logic [3:0]  o_backdrop_color;
  logic        o_video_on, o_frame_int_en, o_bios_sel, o_ram_wr, o_psg_wr;
  rom_addr_t   o_rom_addr;

  // Reference model state
  vdp_latch_e  m_latch;
  byte_t       m_first;
  vram_addr_t  m_vaddr;
  logic        m_cram, m_data_rd_d, m_stat_rd_d, m_int, m_coll;
  byte_t       m_regs [VDP_REG_COUNT];
  byte_t       m_slot [4];
  byte_t       m_mem_ctrl;

  // Decoded view of the bus as driven
  logic        b_io_rd, b_io_wr, b_mem_rd, b_mem_wr;
  io_port_e    b_port;

  logic [31:0] rng;
  int          cyc;
  int          phase;
  int          cycle_count;
  logic        failed;

  sms_system #(.CLK_DIV(CLK_DIV)) u_dut (
    .i_clk   (cpuClock),
    .i_rst_n (n_hard_reset),
    .*
  );

  initial begin
    cpuClock = 1'b0;
    forever #2 cpuClock = ~cpuClock;
  end

  // ============================================================
  // Helpers
  // ============================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      failed = 1'b1;
      $display("ERROR %s expected %h actual %h (cycle %0d)", name, exp, act, cyc);
      $display("TESTS FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic decode_bus();
    b_io_rd  = !i_n_rd && !i_n_iorq;
    b_io_wr  = !i_n_wr && !i_n_iorq;
    b_mem_rd = !i_n_rd && !i_n_mreq;
    b_mem_wr = !i_n_wr && !i_n_mreq;
    case (i_addr[7:6])
      2'b00:   b_port = i_addr[0] ? JOY_CTRL : MEM_CTRL;
      2'b01:   b_port = !i_addr[0] ? V_COUNTER : (b_io_wr ? PSG : H_COUNTER);
      2'b10:   b_port = i_addr[0] ? VDP_CTRL : VDP_DATA;
      default: b_port = i_addr[0] ? JOY1 : JOY0;
    endcase
  endtask

  function automatic logic [7:0] pick_port(input logic [2:0] idx);
    case (idx)
      3'd0:    return 8'h3E;  // Memory control
      3'd1:    return 8'h3F;
      3'd2:    return 8'h7E;  // V counter
      3'd3:    return 8'h7F;  // H counter or PSG
      3'd4:    return 8'hBE;
      3'd5:    return 8'hBF;
      3'd6:    return 8'hDC;  // Pads
      default: return 8'hDD;
    endcase
  endfunction

  task automatic reset_model();
    m_latch     = LATCH_FIRST;
    m_first     = '0;
    m_vaddr     = '0;
    m_cram      = 1'b0;
    m_data_rd_d = 1'b0;
    m_stat_rd_d = 1'b0;
    m_int       = 1'b0;
    m_coll      = 1'b0;
    for (int i = 0; i < VDP_REG_COUNT; i++)
      m_regs[i] = '0;
    m_slot     = '{8'd0, 8'd0, 8'd1, 8'd2};
    m_mem_ctrl = 8'hF7;
  endtask

  // ============================================================
  // Stimulus
  // ============================================================

  task automatic drive_bus_cycle();
    logic [31:0] r;
    logic [7:0]  port_byte;
    rng = xorshift32(rng);
    r   = rng;
    port_byte = r[11] ? (r[12] ? 8'hBF : 8'hBE) : pick_port(r[10:8]);  // Extra VDP weight
    i_n_rd   = !(r[1:0] == 2'd0 || r[1:0] == 2'd2);
    i_n_wr   = !(r[1:0] == 2'd1 || r[1:0] == 2'd3);
    i_n_iorq = r[1];
    i_n_mreq = !r[1];
    if (!r[1])
      i_addr = {r[23:16], port_byte};
    else
      i_addr = r[13] ? {14'h3FFF, r[3:2]} : r[31:16];
    rng = xorshift32(rng);
    i_wdata     = rng[7:0];
    i_vram_data = rng[15:8];
    i_v_counter = rng[23:16];
    i_h_counter = rng[31:24];
    rng = xorshift32(rng);
    i_ram_data  = rng[7:0];
    i_bios_data = rng[15:8];
    i_rom_data  = rng[23:16];
    i_btn       = rng[30:24];
    rng = xorshift32(rng);
    i_too_many_sprites = rng[0];
    i_overflow_sprite  = rng[5:1];
  endtask

  task automatic drive_flags();
    rng = xorshift32(rng);
    i_frame_int        = (rng[2:0] == 3'd0);  // Rare pulses
    i_sprite_collision = (rng[5:3] == 3'd0);
  endtask

  // ============================================================
  // Model update for the coming clock edge
  // ============================================================

  task automatic update_model(input int ph);
    logic edge_now, data_rd, data_wr, ctrl_rd, ctrl_wr, clr;
    edge_now = (ph == 4);
    decode_bus();
    data_rd = b_io_rd && b_port == VDP_DATA;
    data_wr = b_io_wr && b_port == VDP_DATA;
    ctrl_rd = b_io_rd && b_port == VDP_CTRL;
    ctrl_wr = b_io_wr && b_port == VDP_CTRL;

    clr    = edge_now && m_stat_rd_d && !ctrl_rd;  // Status read just ended
    m_int  = clr ? 1'b0 : (m_int | i_frame_int);
    m_coll = clr ? 1'b0 : (m_coll | i_sprite_collision);
    if (!edge_now)
      return;

    m_stat_rd_d = ctrl_rd;
    if (data_wr || (m_data_rd_d && !data_rd))
      m_vaddr = m_vaddr + 1'b1;
    m_data_rd_d = data_rd;
    if (ctrl_rd || data_rd || data_wr)
      m_latch = LATCH_FIRST;
    if (ctrl_wr && m_latch == LATCH_FIRST) begin
      m_first = i_wdata;
      m_latch = LATCH_SECOND;
    end else if (ctrl_wr) begin
      m_latch = LATCH_FIRST;
      if (!i_wdata[7]) begin
        m_vaddr = {i_wdata[5:0], m_first};
        m_cram  = 1'b0;
      end else if (i_wdata[6] == 1'b0 && i_wdata[3:0] < 4'd11) begin
        m_regs[i_wdata[3:0]] = m_first;
      end else begin
        m_vaddr = {8'h00, m_first[5:0]};
        m_cram  = 1'b1;
      end
    end

    if (b_mem_wr && i_addr[15:2] == 14'h3FFF)
      m_slot[i_addr[1:0]] = i_wdata;
    if (b_io_wr && b_port == MEM_CTRL)
      m_mem_ctrl = i_wdata;
  endtask

  // ============================================================
  // Output checks
  // ============================================================

  task automatic check_outputs(input int ph);
    logic       edge_now;
    logic [2:0] mode;
    logic [1:0] page;
    byte_t      status;
    byte_t      exp_rd;
    rom_addr_t  exp_rom;
    edge_now = (ph == 4);
    decode_bus();
    page = i_addr[15:14];
    if (m_regs[0][2])      mode = 3'd4;
    else if (m_regs[1][3]) mode = 3'd3;
    else if (m_regs[0][1]) mode = 3'd2;
    else if (m_regs[1][4]) mode = 3'd1;
    else                   mode = 3'd0;
    status = {m_int, i_too_many_sprites, m_coll,
              i_too_many_sprites ? i_overflow_sprite : 5'h1F};

    compare_value("cpu_clk_en", ph >= 4, o_cpu_clk_en);
    compare_value("vdp_wr", edge_now && b_io_wr && b_port == VDP_DATA, o_vdp_wr);
    compare_value("vdp_rd", edge_now && b_io_rd && b_port == VDP_DATA, o_vdp_rd);
    compare_value("psg_wr", edge_now && b_io_wr && b_port == PSG, o_psg_wr);
    compare_value("vdp_addr", m_vaddr, o_vdp_addr);
    compare_value("cram_selected", m_cram, o_cram_selected);

    // Register fields and table bases
    compare_value("mode", mode, o_mode);
    compare_value("name_table", {m_regs[2][3:1], 11'b0}, o_name_table_addr);
    compare_value("color_table", (mode == 3'd2) ? {m_regs[3][7], 13'b0} :
                  {m_regs[3], 6'b0}, o_color_table_addr);
    compare_value("pattern", (mode == 3'd4) ? 14'd0 : (mode == 3'd2) ?
                  {m_regs[4][2], 13'b0} : {m_regs[4][2:0], 11'b0}, o_pattern_addr);
    compare_value("sprite_attr", {m_regs[5][6:1], 8'b0}, o_sprite_attr_addr);
    compare_value("sprite_pattern", (mode == 3'd4) ? {m_regs[6][2], 13'b0} :
                  {m_regs[6][2:0], 11'b0}, o_sprite_pattern_addr);
    compare_value("backdrop", m_regs[7][3:0], o_backdrop_color);
    compare_value("x_scroll", m_regs[8], o_x_scroll);
    compare_value("y_scroll", m_regs[9], o_y_scroll);
    compare_value("video_on", m_regs[1][6], o_video_on);
    compare_value("frame_int_en", m_regs[1][5], o_frame_int_en);

    // Mapper
    if (page == 2'b11)
      exp_rom = {6'b0, i_addr};
    else
      exp_rom = {m_slot[page + 2'd1], i_addr[13:0]};
    compare_value("rom_addr", exp_rom, o_rom_addr);
    compare_value("bios_sel", !m_mem_ctrl[3], o_bios_sel);
    compare_value("ram_wr", b_mem_wr && page == 2'b11, o_ram_wr);

    // Read data
    if (b_io_rd && b_port == VDP_DATA)       exp_rd = i_vram_data;
    else if (b_io_rd && b_port == VDP_CTRL)  exp_rd = status;
    else if (b_io_rd && b_port == JOY0)      exp_rd = {2'b11, ~i_btn[2:1], ~i_btn[6:3]};
    else if (b_io_rd && b_port == JOY1)      exp_rd = 8'hBF;
    else if (b_io_rd && b_port == V_COUNTER) exp_rd = i_v_counter;
    else if (b_io_rd && b_port == H_COUNTER) exp_rd = i_h_counter;
    else if (b_mem_rd && page != 2'b11)      exp_rd = !m_mem_ctrl[3] ? i_bios_data : i_rom_data;
    else                                     exp_rd = i_ram_data;
    compare_value("cpu_data_in", exp_rd, o_cpu_data_in);
  endtask

  // ============================================================
  // Main sequence and timeout
  // ============================================================

  initial begin
    failed       = 1'b0;
    rng          = 32'h966c_da20;
    n_hard_reset = 1'b0;
    i_addr       = '0;
    i_wdata      = '0;
    i_n_rd       = 1'b1;  // Idle bus
    i_n_wr       = 1'b1;
    i_n_iorq     = 1'b1;
    i_n_mreq     = 1'b1;
    i_frame_int        = 1'b0;
    i_sprite_collision = 1'b0;
    i_too_many_sprites = 1'b0;
    i_overflow_sprite  = '0;
    i_vram_data  = '0;
    i_v_counter  = '0;
    i_h_counter  = '0;
    i_btn        = '0;
    i_ram_data   = '0;
    i_bios_data  = '0;
    i_rom_data   = '0;
    reset_model();
    repeat (4) @(posedge cpuClock);
    @(negedge cpuClock);
    n_hard_reset = 1'b1;
    for (cyc = 0; cyc < RUN_CYC; cyc++) begin
      phase = cyc % CLK_DIV;
      check_outputs(phase);
      if (phase == 5)
        drive_bus_cycle();  // Right after the edge cycle
      drive_flags();
      update_model(phase);
      @(negedge cpuClock);
    end
    if (!failed)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  always @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYC) begin
        $display("Run exceeded %0d cycles without finishing", TIMEOUT_CYC);
        $display("TESTS FAILED");
        $fatal(1, "Timeout");
      end
    end
  end

endmodule

//--- source/sms_system.sv
module sms_system #(
  parameter int CLK_DIV = 7
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  // CPU bus
  input  sms_pkg::cpu_addr_t   i_addr,
  input  sms_pkg::byte_t       i_wdata,
  input  logic                 i_n_rd,
  input  logic                 i_n_wr,
  input  logic                 i_n_iorq,
  input  logic                 i_n_mreq,
  output logic                 o_cpu_clk_en,
  output sms_pkg::byte_t       o_cpu_data_in,
  // Video chip side
  input  logic                 i_frame_int,
  input  logic                 i_sprite_collision,
  input  logic                 i_too_many_sprites,
  input  sms_pkg::sprite_idx_t i_overflow_sprite,
  input  sms_pkg::byte_t       i_vram_data,
  input  sms_pkg::byte_t       i_v_counter,
  input  sms_pkg::byte_t       i_h_counter,
  output sms_pkg::vram_addr_t  o_vdp_addr,
  output logic                 o_vdp_wr,
  output logic                 o_vdp_rd,
  output logic                 o_cram_selected,
  output logic [2:0]           o_mode,
  output sms_pkg::vram_addr_t  o_name_table_addr,
  output sms_pkg::vram_addr_t  o_color_table_addr,
  output sms_pkg::vram_addr_t  o_pattern_addr,
  output sms_pkg::vram_addr_t  o_sprite_attr_addr,
  output sms_pkg::vram_addr_t  o_sprite_pattern_addr,
  output sms_pkg::byte_t       o_x_scroll,
  output sms_pkg::byte_t       o_y_scroll,
  output logic [3:0]           o_backdrop_color,
  output logic                 o_video_on,
  output logic                 o_frame_int_en,
  // Memory, pads and sound
  input  logic [6:0]           i_btn,
  input  sms_pkg::byte_t       i_ram_data,
  input  sms_pkg::byte_t       i_bios_data,
  input  sms_pkg::byte_t       i_rom_data,
  output sms_pkg::rom_addr_t   o_rom_addr,
  output logic                 o_bios_sel,
  output logic                 o_ram_wr,
  output logic                 o_psg_wr
);

  sms_pkg::byte_t status;

  cpu_bus_if bus ();

  sms_io_decode #(.CLK_DIV(CLK_DIV)) u_io_decode (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .i_n_rd       (i_n_rd),
    .i_n_wr       (i_n_wr),
    .i_n_iorq     (i_n_iorq),
    .i_n_mreq     (i_n_mreq),
    .o_cpu_clk_en (o_cpu_clk_en),
    .bus          (bus.decoder)
  );

  vdp_port u_vdp_port (
    .i_clk                 (i_clk),
    .i_rst_n               (i_rst_n),
    .bus                   (bus.sink),
    .o_vdp_addr            (o_vdp_addr),
    .o_vdp_wr              (o_vdp_wr),
    .o_vdp_rd              (o_vdp_rd),
    .o_cram_selected       (o_cram_selected),
    .o_mode                (o_mode),
    .o_name_table_addr     (o_name_table_addr),
    .o_color_table_addr    (o_color_table_addr),
    .o_pattern_addr        (o_pattern_addr),
    .o_sprite_attr_addr    (o_sprite_attr_addr),
    .o_sprite_pattern_addr (o_sprite_pattern_addr),
    .o_x_scroll            (o_x_scroll),
    .o_y_scroll            (o_y_scroll),
    .o_backdrop_color      (o_backdrop_color),
    .o_video_on            (o_video_on),
    .o_frame_int_en        (o_frame_int_en)
  );

  vdp_status u_vdp_status (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .bus                (bus.sink),
    .i_frame_int        (i_frame_int),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_overflow_sprite  (i_overflow_sprite),
    .o_status           (status)
  );

  mem_mapper u_mem_mapper (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .bus        (bus.sink),
    .o_rom_addr (o_rom_addr),
    .o_bios_sel (o_bios_sel),
    .o_ram_wr   (o_ram_wr),
    .o_psg_wr   (o_psg_wr)
  );

  sms_read_mux u_read_mux (
    .bus           (bus.sink),
    .i_vram_data   (i_vram_data),
    .i_status      (status),
    .i_v_counter   (i_v_counter),
    .i_h_counter   (i_h_counter),
    .i_btn         (i_btn),
    .i_bios_sel    (o_bios_sel),
    .i_ram_data    (i_ram_data),
    .i_bios_data   (i_bios_data),
    .i_rom_data    (i_rom_data),
    .o_cpu_data_in (o_cpu_data_in)
  );

endmodule

//--- source/sms_read_mux.sv
module sms_read_mux (
  cpu_bus_if.sink        bus,
  input  sms_pkg::byte_t i_vram_data,
  input  sms_pkg::byte_t i_status,
  input  sms_pkg::byte_t i_v_counter,
  input  sms_pkg::byte_t i_h_counter,
  input  logic [6:0]     i_btn,
  input  logic           i_bios_sel,
  input  sms_pkg::byte_t i_ram_data,
  input  sms_pkg::byte_t i_bios_data,
  input  sms_pkg::byte_t i_rom_data,
  output sms_pkg::byte_t o_cpu_data_in
);
  import sms_pkg::*;

  byte_t joy0_data;
  byte_t joy1_data;

  // Buttons are active low on the controller port
  assign joy0_data = {2'b11, ~i_btn[2:1], ~i_btn[6:3]};
  assign joy1_data = 8'hBF;               // Second pad absent

  always_comb begin
    if (bus.io_rd && bus.port == VDP_DATA)
      o_cpu_data_in = i_vram_data;
    else if (bus.io_rd && bus.port == VDP_CTRL)
      o_cpu_data_in = i_status;
    else if (bus.io_rd && bus.port == JOY0)
      o_cpu_data_in = joy0_data;
    else if (bus.io_rd && bus.port == JOY1)
      o_cpu_data_in = joy1_data;
    else if (bus.io_rd && bus.port == V_COUNTER)
      o_cpu_data_in = i_v_counter;
    else if (bus.io_rd && bus.port == H_COUNTER)
      o_cpu_data_in = i_h_counter;
    else if (bus.mem_rd && bus.addr[15:14] != 2'b11)
      o_cpu_data_in = i_bios_sel ? i_bios_data : i_rom_data;
    else
      o_cpu_data_in = i_ram_data;         // Page 3 and idle bus
  end

endmodule

//--- source/mem_mapper.sv
module mem_mapper (
  input  logic               i_clk,
  input  logic               i_rst_n,
  cpu_bus_if.sink            bus,
  output sms_pkg::rom_addr_t o_rom_addr,
  output logic               o_bios_sel,
  output logic               o_ram_wr,
  output logic               o_psg_wr
);
  import sms_pkg::*;

  byte_t slot_regs [4]; // FFFC misc, then slots for pages 0 to 2
  byte_t mem_ctrl;
  logic  [1:0] page;

  assign page = bus.addr[15:14];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      slot_regs[0] <= 8'd0;
      slot_regs[1] <= 8'd0;
      slot_regs[2] <= 8'd1;
      slot_regs[3] <= 8'd2;
      mem_ctrl     <= MEM_CTRL_RESET;
    end else if (bus.cpu_edge) begin
      if (bus.mem_wr && bus.addr[15:2] == 14'h3FFF)
        slot_regs[bus.addr[1:0]] <= bus.wdata;
      if (bus.io_wr && bus.port == MEM_CTRL)
        mem_ctrl <= bus.wdata;
    end
  end

  // Page 3 is RAM, so the raw address passes through
  always_comb begin
    if (page == 2'b11)
      o_rom_addr = rom_addr_t'(bus.addr);
    else
      o_rom_addr = {slot_regs[page + 2'd1], bus.addr[13:0]};
  end

  assign o_bios_sel = !mem_ctrl[3];
  assign o_ram_wr   = bus.mem_wr && page == 2'b11;
  assign o_psg_wr   = bus.io_wr && bus.port == PSG && bus.cpu_edge;

  // Memory and I/O requests must not overlap on the CPU bus
  a_wr_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_ram_wr && o_psg_wr));

endmodule

//--- source/vdp_status.sv
module vdp_status (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  cpu_bus_if.sink              bus,
  input  logic                 i_frame_int,
  input  logic                 i_sprite_collision,
  input  logic                 i_too_many_sprites,
  input  sms_pkg::sprite_idx_t i_overflow_sprite,
  output sms_pkg::byte_t       o_status
);
  import sms_pkg::*;

  logic int_flag;
  logic coll_flag;
  logic stat_rd;
  logic stat_rd_d;

  assign stat_rd = bus.io_rd && bus.port == VDP_CTRL;

  // Flags capture every cycle, clear once the status read is over
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      int_flag  <= 1'b0;
      coll_flag <= 1'b0;
      stat_rd_d <= 1'b0;
    end else begin
      if (i_frame_int)
        int_flag <= 1'b1;
      if (i_sprite_collision)
        coll_flag <= 1'b1;
      if (bus.cpu_edge) begin
        stat_rd_d <= stat_rd;
        if (stat_rd_d && !stat_rd) begin
          int_flag  <= 1'b0;
          coll_flag <= 1'b0;
        end
      end
    end
  end

  assign o_status = {int_flag, i_too_many_sprites, coll_flag,
                     i_too_many_sprites ? i_overflow_sprite : 5'b11111};

endmodule

//--- source/vdp_port.sv
module vdp_port (
  input  logic                i_clk,
  input  logic                i_rst_n,
  cpu_bus_if.sink             bus,
  output sms_pkg::vram_addr_t o_vdp_addr,
  output logic                o_vdp_wr,
  output logic                o_vdp_rd,
  output logic                o_cram_selected,
  output logic [2:0]          o_mode,
  output sms_pkg::vram_addr_t o_name_table_addr,
  output sms_pkg::vram_addr_t o_color_table_addr,
  output sms_pkg::vram_addr_t o_pattern_addr,
  output sms_pkg::vram_addr_t o_sprite_attr_addr,
  output sms_pkg::vram_addr_t o_sprite_pattern_addr,
  output sms_pkg::byte_t      o_x_scroll,
  output sms_pkg::byte_t      o_y_scroll,
  output logic [3:0]          o_backdrop_color,
  output logic                o_video_on,
  output logic                o_frame_int_en
);
  import sms_pkg::*;

  vdp_latch_e latch;
  byte_t      first_byte;
  vram_addr_t vram_addr;
  logic       cram_sel;
  logic       data_rd_d;                 // Data read seen on the last edge
  byte_t      regs [VDP_REG_COUNT];

  logic       data_wr, data_rd, ctrl_wr, ctrl_rd;
  logic       reg_wr;
  logic [3:0] reg_idx;
  logic       m1, m2, m3, m4;

  assign data_wr = bus.io_wr && bus.port == VDP_DATA;
  assign data_rd = bus.io_rd && bus.port == VDP_DATA;
  assign ctrl_wr = bus.io_wr && bus.port == VDP_CTRL;
  assign ctrl_rd = bus.io_rd && bus.port == VDP_CTRL;

  assign reg_idx = bus.wdata[3:0];
  assign reg_wr  = ctrl_wr && latch == LATCH_SECOND && bus.wdata[7:6] == 2'b10 &&
                   reg_idx < VDP_REG_COUNT;

  // ============================================================
  // Control latch, address and register file
  // ============================================================

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      latch      <= LATCH_FIRST;
      first_byte <= '0;
      vram_addr  <= '0;
      cram_sel   <= 1'b0;
      data_rd_d  <= 1'b0;
      for (int i = 0; i < VDP_REG_COUNT; i++)
        regs[i] <= '0;
    end else if (bus.cpu_edge) begin
      data_rd_d <= data_rd;
      if (data_wr)
        vram_addr <= vram_addr + 1'b1;
      if (data_rd_d && !data_rd)
        vram_addr <= vram_addr + 1'b1; // Read has ended

      if (ctrl_rd || data_rd || data_wr)
        latch <= LATCH_FIRST;

      if (ctrl_wr) begin
        if (latch == LATCH_SECOND) begin
          latch <= LATCH_FIRST;
          if (!bus.wdata[7]) begin
            // Bit 6 (read or write next) is ignored
            vram_addr <= {bus.wdata[5:0], first_byte};
            cram_sel  <= 1'b0;
          end else if (reg_wr) begin
            regs[reg_idx] <= first_byte;
          end else begin
            vram_addr <= vram_addr_t'(first_byte[5:0]); // CRAM entry
            cram_sel  <= 1'b1;
          end
        end else begin
          first_byte <= bus.wdata;
          latch      <= LATCH_SECOND;
        end
      end
    end
  end

  assign o_vdp_addr      = vram_addr;
  assign o_cram_selected = cram_sel;
  assign o_vdp_wr        = data_wr && bus.cpu_edge;
  assign o_vdp_rd        = data_rd && bus.cpu_edge;

  // ============================================================
  // Display mode and table bases
  // ============================================================

  assign m1 = regs[1][4];
  assign m2 = regs[0][1];
  assign m3 = regs[1][3];
  assign m4 = regs[0][2];

  assign o_mode = m4 ? 3'd4 : m3 ? 3'd3 : m2 ? 3'd2 : m1 ? 3'd1 : 3'd0;

  assign o_name_table_addr  = {regs[2][3:1], 11'b0};
  assign o_color_table_addr = (o_mode == 3'd2) ? {regs[3][7], 13'b0} : {regs[3], 6'b0};
  assign o_pattern_addr     = (o_mode == 3'd4) ? '0 :
                              (o_mode == 3'd2) ? {regs[4][2], 13'b0} :
                                                 {regs[4][2:0], 11'b0};
  assign o_sprite_attr_addr    = {regs[5][6:1], 8'b0};
  assign o_sprite_pattern_addr = (o_mode == 3'd4) ? {regs[6][2], 13'b0} :
                                                    {regs[6][2:0], 11'b0};

  assign o_x_scroll       = regs[8];
  assign o_y_scroll       = regs[9];
  assign o_backdrop_color = regs[7][3:0];
  assign o_video_on       = regs[1][6];
  assign o_frame_int_en   = regs[1][5];

  // Register command past the last register becomes a CRAM address load
  a_reg_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (bus.cpu_edge && ctrl_wr && latch == LATCH_SECOND && bus.wdata[7:6] == 2'b10 &&
     reg_idx >= 4'(VDP_REG_COUNT)) |=> cram_sel);

endmodule

//--- source/sms_io_decode.sv
module sms_io_decode #(
  parameter int CLK_DIV = 7
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  sms_pkg::cpu_addr_t i_addr,
  input  sms_pkg::byte_t    i_wdata,
  input  logic              i_n_rd,
  input  logic              i_n_wr,
  input  logic              i_n_iorq,
  input  logic              i_n_mreq,
  output logic              o_cpu_clk_en,
  cpu_bus_if.decoder        bus
);
  import sms_pkg::*;

  localparam int CNT_W = $clog2(CLK_DIV);

  logic [CNT_W-1:0] div_cnt;
  logic             clk_en;
  logic             clk_en_d;

  // ============================================================
  // CPU clock enable
  // ============================================================

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      div_cnt  <= '0;
      clk_en_d <= 1'b0;
    end else begin
      clk_en_d <= clk_en;
      if (div_cnt == CNT_W'(CLK_DIV - 1))
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 1'b1;
    end
  end

  // High for the top part of the count, three cycles at the default ratio
  assign clk_en       = (div_cnt >= CNT_W'(4));
  assign o_cpu_clk_en = clk_en;
  assign bus.cpu_edge = clk_en && !clk_en_d; // Rising edge of the enable

  // ============================================================
  // Strobes and port decode
  // ============================================================

  assign bus.addr   = i_addr;
  assign bus.wdata  = i_wdata;
  assign bus.io_rd  = !i_n_rd && !i_n_iorq;
  assign bus.io_wr  = !i_n_wr && !i_n_iorq;
  assign bus.mem_rd = !i_n_rd && !i_n_mreq;
  assign bus.mem_wr = !i_n_wr && !i_n_mreq;

  always_comb begin
    case ({i_addr[7:6], i_addr[0]})
      3'b000:  bus.port = MEM_CTRL;
      3'b001:  bus.port = JOY_CTRL;
      3'b010:  bus.port = V_COUNTER;
      3'b011:  bus.port = bus.io_wr ? PSG : H_COUNTER; // Shared address
      3'b100:  bus.port = VDP_DATA;
      3'b101:  bus.port = VDP_CTRL;
      3'b110:  bus.port = JOY0;
      default: bus.port = JOY1;
    endcase
  end

  // Every register block relies on a single edge per bus cycle
  a_edge_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    bus.cpu_edge |=> !bus.cpu_edge);

endmodule

//--- source/cpu_bus_if.sv
// One decoded CPU bus cycle, shared by all register blocks
interface cpu_bus_if;
  import sms_pkg::*;

  cpu_addr_t addr;
  byte_t     wdata;
  io_port_e  port;

  // Active-high strobe levels
  logic io_rd;
  logic io_wr;
  logic mem_rd;
  logic mem_wr;

  logic cpu_edge; // One cycle per CPU enable period

  modport decoder (
    output addr,
    output wdata,
    output port,
    output io_rd,
    output io_wr,
    output mem_rd,
    output mem_wr,
    output cpu_edge
  );

  modport sink (
    input addr,
    input wdata,
    input port,
    input io_rd,
    input io_wr,
    input mem_rd,
    input mem_wr,
    input cpu_edge
  );

endinterface

//--- source/sms_pkg.sv
package sms_pkg;

  // ============================================================
  // Bus and datapath widths
  // ============================================================

  typedef logic [15:0] cpu_addr_t;   // Z80 address bus
  typedef logic [7:0]  byte_t;       // Data byte, register value or counter
  typedef logic [13:0] vram_addr_t;  // VRAM address and table bases
  typedef logic [21:0] rom_addr_t;   // Mapped cartridge address
  typedef logic [4:0]  sprite_idx_t; // Overflowing sprite index

  // ============================================================
  // Decoded I/O ports
  // ============================================================

  // Port is selected by address bits 7:6 and bit 0
  typedef enum logic [3:0] {
    VDP_DATA,
    VDP_CTRL,
    PSG,       // Write side of 0x41
    JOY0,
    JOY1,
    MEM_CTRL,
    JOY_CTRL,
    V_COUNTER,
    H_COUNTER  // Read side of 0x41
  } io_port_e;

  // Two-byte control port sequence
  typedef enum logic {
    LATCH_FIRST,
    LATCH_SECOND
  } vdp_latch_e;

  localparam int VDP_REG_COUNT = 11;

  localparam byte_t MEM_CTRL_RESET = 8'hF7; // BIOS enabled, cartridge off

endpackage
